// File: verilog/fetch_cfg.svh
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// pc and csr width
`define XLEN 64

// one rv64 instruction, no compressed forms
`define INST_LEN 32

// first fetch lands here, pc register sits one word below
`define RESET_PC 64'h8000_0000

// index width of the 64-bit sram words, 256 words = 2 KB
`define IMEM_AW 8

// apb offset of the program window, upper half of the 4 KB map
`define APB_IMEM_BASE 12'h800

`endif

// File: verilog/fetch_pkg.sv
`include "fetch_cfg.svh"

package fetch_pkg;

    // redirect requests from later stages, jump has top priority
    typedef struct packed {
        logic             jump;
        logic [`XLEN-1:0] jump_target;
        logic             trap_enter;
        logic             trap_return;
    } redirect_t;

    // fetched instruction and the pc it came from
    typedef struct packed {
        logic                 valid;
        logic [`XLEN-1:0]     pc;
        logic [`INST_LEN-1:0] instr;
    } fetch_out_t;

    // apb master side
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [11:0] paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    // apb slave side
    typedef struct packed {
        logic        pready;
        logic        pslverr;
        logic [31:0] prdata;
    } apb_rsp_t;

    // half-word program write into the instruction sram
    typedef struct packed {
        logic                we;
        logic [`IMEM_AW-1:0] idx;
        logic [1:0]          strb;
        logic [31:0]         data;
    } imem_wr_t;

    // csr byte offsets in the apb map
    typedef enum logic [11:0] {
        MTVEC_LO = 12'h000,
        MTVEC_HI = 12'h004,
        MEPC_LO  = 12'h008,
        MEPC_HI  = 12'h00C
    } csr_idx_e;

endpackage

// File: verilog/if_stage.sv
`timescale 1ns/10ps
`include "fetch_cfg.svh"

module if_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  fetch_pkg::redirect_t  redirect_i,
    input  logic                  stall_n_i,
    input  logic [`XLEN-1:0]      mtvec_i,
    input  logic [`XLEN-1:0]      mepc_i,
    output logic                  imem_ren_o,
    output logic [`IMEM_AW-1:0]   imem_addr_o,
    input  logic [63:0]           imem_rdata_i,
    input  logic                  imem_valid_i,
    output fetch_pkg::fetch_out_t fetch_o
);

    logic [`XLEN-1:0] pc_q;
    logic [`XLEN-1:0] next_pc;
    logic             run_q;
    logic             advance;

    // goes high one cycle after reset release
    // so no read is issued while reset is still settling
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
        end
    end

    // stall freezes both the pc and the sram request
    assign advance = stall_n_i & run_q;

    // jump first, then trap entry, then trap return, then sequential
    always_comb begin
        if (redirect_i.jump) begin
            next_pc = redirect_i.jump_target;
        end else if (redirect_i.trap_enter) begin
            next_pc = mtvec_i;
        end else if (redirect_i.trap_return) begin
            next_pc = mepc_i;
        end else begin
            next_pc = pc_q + `XLEN'd4;
        end
    end

    // pc register starts one word below the reset vector
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= `RESET_PC - `XLEN'd4;
        end else if (advance) begin
            pc_q <= next_pc;
        end
    end

    // sram request for next_pc with bits above the array dropped
    assign imem_ren_o  = advance;
    assign imem_addr_o = next_pc[`IMEM_AW+2:3];

    // sram data lines up with pc_q one cycle after the request
    always_comb begin
        fetch_o.valid = imem_valid_i;
        fetch_o.pc    = pc_q;
        // bit 2 picks the upper or lower instruction of the word
        fetch_o.instr = pc_q[2] ? imem_rdata_i[63:32] : imem_rdata_i[31:0];
    end

    // at most one trap flag per cycle
    a_trap_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        !(redirect_i.trap_enter && redirect_i.trap_return));

    // every pc handed on is word aligned
    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_o.valid |-> (fetch_o.pc[1:0] == 2'b00));

endmodule

// File: verilog/imem_sram.sv
`timescale 1ns/10ps
`include "fetch_cfg.svh"

module imem_sram (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 ren_i,
    input  logic [`IMEM_AW-1:0]  raddr_i,
    output logic [63:0]          rdata_o,
    output logic                 rvalid_o,
    input  fetch_pkg::imem_wr_t  wr_i
);

    localparam int DEPTH = 1 << `IMEM_AW;

    // two instructions per word
    logic [63:0] mem [DEPTH];

    // program load, each strobe bit covers one 32-bit half
    always_ff @(posedge clk) begin
        if (wr_i.we) begin
            if (wr_i.strb[0]) begin
                mem[wr_i.idx][31:0] <= wr_i.data;
            end
            if (wr_i.strb[1]) begin
                mem[wr_i.idx][63:32] <= wr_i.data;
            end
        end
    end

    // registered read port
    // output holds when no read is issued
    always_ff @(posedge clk) begin
        if (ren_i) begin
            rdata_o <= mem[raddr_i];
        end
    end

    // valid after the first read, then sticky
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid_o <= 1'b0;
        end else if (ren_i) begin
            rvalid_o <= 1'b1;
        end
    end

    // a write always targets at least one half
    a_wr_strb: assert property (@(posedge clk) disable iff (!rst_n)
        wr_i.we |-> (wr_i.strb != 2'b00));

endmodule

// File: verilog/fetch_csr_apb.sv
`timescale 1ns/10ps
`include "fetch_cfg.svh"

module fetch_csr_apb (
    input  logic                 clk,
    input  logic                 rst_n,
    input  fetch_pkg::apb_req_t  apb_i,
    output fetch_pkg::apb_rsp_t  apb_o,
    output logic [`XLEN-1:0]     mtvec_o,
    output logic [`XLEN-1:0]     mepc_o,
    output fetch_pkg::imem_wr_t  imem_wr_o
);

    logic             setup;
    logic             access;
    logic             in_win;
    logic             csr_hit;
    logic [11:0]      win_off;
    logic [31:0]      csr_rdata;
    logic             rd_err;
    logic [31:0]      prdata_q;
    logic             pslverr_q;

    assign setup  = apb_i.psel & ~apb_i.penable;
    assign access = apb_i.psel & apb_i.penable;

    // program window, word aligned only
    assign win_off = apb_i.paddr - `APB_IMEM_BASE;
    assign in_win  = (apb_i.paddr >= `APB_IMEM_BASE) && (apb_i.paddr[1:0] == 2'b00);

    // csr decode and read mux
    always_comb begin
        csr_hit   = 1'b1;
        csr_rdata = 32'h0;
        case (fetch_pkg::csr_idx_e'(apb_i.paddr))
            fetch_pkg::MTVEC_LO: csr_rdata = mtvec_o[31:0];
            fetch_pkg::MTVEC_HI: csr_rdata = mtvec_o[63:32];
            fetch_pkg::MEPC_LO:  csr_rdata = mepc_o[31:0];
            fetch_pkg::MEPC_HI:  csr_rdata = mepc_o[63:32];
            default:             csr_hit   = 1'b0;
        endcase
    end

    // window is write only, anything outside the map errors either way
    assign rd_err = apb_i.pwrite ? !(csr_hit || in_win) : !csr_hit;

    // response prepared in setup, shown during access
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prdata_q  <= 32'h0;
            pslverr_q <= 1'b0;
        end else begin
            prdata_q  <= (setup && !apb_i.pwrite && csr_hit) ? csr_rdata : 32'h0;
            pslverr_q <= setup & rd_err;
        end
    end

    // zero wait states
    assign apb_o.pready  = 1'b1;
    assign apb_o.pslverr = pslverr_q;
    assign apb_o.prdata  = prdata_q;

    // trap registers, written a 32-bit half at a time
    // new value visible the cycle after the access phase
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtvec_o <= '0;
            mepc_o  <= '0;
        end else if (access && apb_i.pwrite && csr_hit) begin
            case (fetch_pkg::csr_idx_e'(apb_i.paddr))
                fetch_pkg::MTVEC_LO: mtvec_o[31:0]  <= apb_i.pwdata;
                fetch_pkg::MTVEC_HI: mtvec_o[63:32] <= apb_i.pwdata;
                fetch_pkg::MEPC_LO:  mepc_o[31:0]   <= apb_i.pwdata;
                fetch_pkg::MEPC_HI:  mepc_o[63:32]  <= apb_i.pwdata;
                default: ;
            endcase
        end
    end

    // program window write becomes a one-cycle sram half write
    always_comb begin
        imem_wr_o.we   = access & apb_i.pwrite & in_win;
        imem_wr_o.idx  = win_off[`IMEM_AW+2:3];
        // offset bit 2 picks the upper half
        imem_wr_o.strb = win_off[2] ? 2'b10 : 2'b01;
        imem_wr_o.data = apb_i.pwdata;
    end

    // access phase only ever follows a selected setup
    a_penable_psel: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(apb_i.penable) |-> apb_i.psel);

endmodule

// File: verilog/fetch_top.sv
`timescale 1ns/10ps
`include "fetch_cfg.svh"

module fetch_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  fetch_pkg::apb_req_t   apb_i,
    output fetch_pkg::apb_rsp_t   apb_o,
    input  fetch_pkg::redirect_t  redirect_i,
    input  logic                  stall_n_i,
    output fetch_pkg::fetch_out_t fetch_o
);

    // trap vectors, apb slave to fetch
    logic [`XLEN-1:0]    mtvec;
    logic [`XLEN-1:0]    mepc;

    // program load path
    fetch_pkg::imem_wr_t imem_wr;

    // fetch read port
    logic                imem_ren;
    logic [`IMEM_AW-1:0] imem_addr;
    logic [63:0]         imem_rdata;
    logic                imem_valid;

    fetch_csr_apb u_csr (
        .clk       (clk),
        .rst_n     (rst_n),
        .apb_i     (apb_i),
        .apb_o     (apb_o),
        .mtvec_o   (mtvec),
        .mepc_o    (mepc),
        .imem_wr_o (imem_wr)
    );

    imem_sram u_imem (
        .clk      (clk),
        .rst_n    (rst_n),
        .ren_i    (imem_ren),
        .raddr_i  (imem_addr),
        .rdata_o  (imem_rdata),
        .rvalid_o (imem_valid),
        .wr_i     (imem_wr)
    );

    if_stage u_if (
        .clk          (clk),
        .rst_n        (rst_n),
        .redirect_i   (redirect_i),
        .stall_n_i    (stall_n_i),
        .mtvec_i      (mtvec),
        .mepc_i       (mepc),
        .imem_ren_o   (imem_ren),
        .imem_addr_o  (imem_addr),
        .imem_rdata_i (imem_rdata),
        .imem_valid_i (imem_valid),
        .fetch_o      (fetch_o)
    );

endmodule

// File: bench/fetch_checker.sv
`timescale 1ns/10ps
`include "fetch_cfg.svh"

module fetch_checker (
    input  logic                  clk,
    input  logic                  rst_n,
    input  fetch_pkg::apb_req_t   apb_req_i,
    input  fetch_pkg::apb_rsp_t   apb_rsp_i,
    input  fetch_pkg::redirect_t  redirect_i,
    input  logic                  stall_n_i,
    input  fetch_pkg::fetch_out_t fetch_i,
    output int                    err_cnt_o,
    output int                    chk_cnt_o
);

    // two instructions per 64-bit sram word
    localparam int NINST = 2 << `IMEM_AW;

    logic [`INST_LEN-1:0] model_mem [NINST];
    logic [`XLEN-1:0]     m_mtvec;
    logic [`XLEN-1:0]     m_mepc;
    logic [`XLEN-1:0]     exp_pc;
    logic [`INST_LEN-1:0] exp_instr;
    logic                 exp_valid;
    logic                 m_run;
    int                   errs = 0;
    int                   checks = 0;

    assign err_cnt_o = errs;
    assign chk_cnt_o = checks;

    // instruction slot of a pc, bits above the memory wrap around
    function automatic logic [`IMEM_AW:0] slot_of(input logic [`XLEN-1:0] pc);
        logic [`XLEN-1:0] off;
        off = pc - `RESET_PC;
        return off[`IMEM_AW+2:2];
    endfunction

    function automatic logic is_csr(input logic [11:0] addr);
        return addr == fetch_pkg::MTVEC_LO || addr == fetch_pkg::MTVEC_HI ||
               addr == fetch_pkg::MEPC_LO  || addr == fetch_pkg::MEPC_HI;
    endfunction

    // program window, word offsets only
    function automatic logic in_window(input logic [11:0] addr);
        return addr >= `APB_IMEM_BASE && addr[1:0] == 2'b00;
    endfunction

    function automatic logic [31:0] csr_half(input logic [11:0] addr);
        case (addr)
            fetch_pkg::MTVEC_LO: return m_mtvec[31:0];
            fetch_pkg::MTVEC_HI: return m_mtvec[63:32];
            fetch_pkg::MEPC_LO:  return m_mepc[31:0];
            fetch_pkg::MEPC_HI:  return m_mepc[63:32];
            default:             return 32'h0;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        checks++;
        if (exp !== act) begin
            errs++;
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    // fetch output seen just before the edge
    task automatic check_fetch();
        check_value("fetch_o.valid", 64'(exp_valid), 64'(fetch_i.valid));
        check_value("fetch_o.pc", exp_pc, fetch_i.pc);
        // data is undefined until the first read
        if (exp_valid) begin
            check_value("fetch_o.instr", 64'(exp_instr), 64'(fetch_i.instr));
        end
    endtask

    task automatic check_apb();
        logic exp_err;
        if (apb_req_i.psel && apb_req_i.penable) begin
            // window is write only, unmapped errors both ways
            if (apb_req_i.pwrite) begin
                exp_err = !(is_csr(apb_req_i.paddr) || in_window(apb_req_i.paddr));
            end else begin
                exp_err = !is_csr(apb_req_i.paddr);
            end
            check_value("apb_o.pready", 64'(1'b1), 64'(apb_rsp_i.pready));
            check_value("apb_o.pslverr", 64'(exp_err), 64'(apb_rsp_i.pslverr));
            if (!apb_req_i.pwrite && !exp_err) begin
                check_value("apb_o.prdata", 64'(csr_half(apb_req_i.paddr)),
                            64'(apb_rsp_i.prdata));
            end
        end else begin
            // no error outside the access phase
            check_value("apb_o.pslverr", 64'(1'b0), 64'(apb_rsp_i.pslverr));
        end
    endtask

    // next pc by redirect priority, data shows up one cycle later
    task automatic advance_model();
        logic [`XLEN-1:0] target;
        if (m_run && stall_n_i) begin
            target = exp_pc + 64'd4;
            if (redirect_i.trap_return) target = m_mepc;
            if (redirect_i.trap_enter) target = m_mtvec;
            if (redirect_i.jump) target = redirect_i.jump_target;
            exp_pc    = target;
            exp_valid = 1'b1;
            exp_instr = model_mem[slot_of(target)];
        end
        // fetch starts one cycle after reset release
        m_run = 1'b1;
    endtask

    // writes land after the fetch of this edge has read its data
    task automatic apply_apb_write();
        logic [11:0] off;
        if (apb_req_i.psel && apb_req_i.penable && apb_req_i.pwrite) begin
            off = apb_req_i.paddr - `APB_IMEM_BASE;
            if (in_window(apb_req_i.paddr)) begin
                model_mem[off[`IMEM_AW+2:2]] = apb_req_i.pwdata;
            end else begin
                case (apb_req_i.paddr)
                    fetch_pkg::MTVEC_LO: m_mtvec[31:0]  = apb_req_i.pwdata;
                    fetch_pkg::MTVEC_HI: m_mtvec[63:32] = apb_req_i.pwdata;
                    fetch_pkg::MEPC_LO:  m_mepc[31:0]   = apb_req_i.pwdata;
                    fetch_pkg::MEPC_HI:  m_mepc[63:32]  = apb_req_i.pwdata;
                    default: ;
                endcase
            end
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            exp_pc    = `RESET_PC - 64'd4;
            exp_valid = 1'b0;
            exp_instr = '0;
            m_run     = 1'b0;
            m_mtvec   = '0;
            m_mepc    = '0;
        end else begin
            check_fetch();
            check_apb();
            advance_model();
            apply_apb_write();
        end
    end

endmodule

// File: bench/tb_fetch.sv
`timescale 1ns/10ps
`include "fetch_cfg.svh"

module tb_fetch;

    // longest any single wait may take in cycles
    localparam int WAIT_LIMIT = 32;
    localparam int NINST = 2 << `IMEM_AW;

    logic                  clk;
    logic                  rst_n;
    fetch_pkg::apb_req_t   apb_req;
    fetch_pkg::apb_rsp_t   apb_rsp;
    fetch_pkg::redirect_t  redirect;
    logic                  stall_n;
    fetch_pkg::fetch_out_t fetch;
    int                    seed;
    int                    timeouts;
    int                    err_cnt;
    int                    chk_cnt;

    fetch_top dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .apb_i      (apb_req),
        .apb_o      (apb_rsp),
        .redirect_i (redirect),
        .stall_n_i  (stall_n),
        .fetch_o    (fetch)
    );

    fetch_checker chk (
        .clk        (clk),
        .rst_n      (rst_n),
        .apb_req_i  (apb_req),
        .apb_rsp_i  (apb_rsp),
        .redirect_i (redirect),
        .stall_n_i  (stall_n),
        .fetch_i    (fetch),
        .err_cnt_o  (err_cnt),
        .chk_cnt_o  (chk_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // jump or trap target somewhere in the 2 KB program
    function automatic logic [63:0] rand_target();
        logic [31:0] r;
        r = $random(seed);
        return `RESET_PC + 64'(r & 32'h7FC);
    endfunction

    // setup then access ending on the edge that sees pready
    task automatic apb_xfer(input logic write, input logic [11:0] addr,
                            input logic [31:0] data);
        int cycles;
        if (timeouts != 0) return;
        @(posedge clk);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= write;
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= data;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        cycles = 0;
        @(posedge clk);
        while (!apb_rsp.pready && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
        if (cycles == WAIT_LIMIT) begin
            timeouts++;
            $display("timeout: APB transfer to offset %h never saw pready", addr);
        end
    endtask

    task automatic write_csr64(input logic [11:0] lo_addr, input logic [63:0] value);
        apb_xfer(1'b1, lo_addr, value[31:0]);
        apb_xfer(1'b1, lo_addr + 12'd4, value[63:32]);
    endtask

    task automatic read_csrs();
        apb_xfer(1'b0, fetch_pkg::MTVEC_LO, 32'h0);
        apb_xfer(1'b0, fetch_pkg::MTVEC_HI, 32'h0);
        apb_xfer(1'b0, fetch_pkg::MEPC_LO, 32'h0);
        apb_xfer(1'b0, fetch_pkg::MEPC_HI, 32'h0);
    endtask

    // fill every instruction slot in both halves of each word
    task automatic load_program();
        for (int i = 0; i < NINST; i++) begin
            apb_xfer(1'b1, `APB_IMEM_BASE + 12'(i * 4), $random(seed));
        end
    endtask

    task automatic drive_cycle(input logic run, input logic jump, input logic [63:0] target,
                               input logic enter, input logic ret);
        if (timeouts != 0) return;
        @(posedge clk);
        stall_n              <= run;
        redirect.jump        <= jump;
        redirect.jump_target <= target;
        redirect.trap_enter  <= enter;
        redirect.trap_return <= ret;
    endtask

    task automatic hold_fetch();
        drive_cycle(1'b0, 1'b0, 64'h0, 1'b0, 1'b0);
    endtask

    task automatic run_sequential(input int n);
        repeat (n) drive_cycle(1'b1, 1'b0, 64'h0, 1'b0, 1'b0);
    endtask

    // release stall and wait for the first valid fetch
    task automatic wait_first_fetch();
        int cycles;
        if (timeouts != 0) return;
        cycles = 0;
        drive_cycle(1'b1, 1'b0, 64'h0, 1'b0, 1'b0);
        @(posedge clk);
        while (!fetch.valid && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (!fetch.valid) begin
            timeouts++;
            $display("timeout: fetch_o.valid never rose after the stall was released");
        end
    endtask

    task automatic run_random(input int n);
        logic [31:0] r;
        for (int i = 0; i < n; i++) begin
            r = $random(seed);
            if (r[15:10] == 6'd0) begin
                // park fetch and move one trap vector
                hold_fetch();
                if (r[16]) begin
                    write_csr64(fetch_pkg::MTVEC_LO, rand_target());
                end else begin
                    write_csr64(fetch_pkg::MEPC_LO, rand_target());
                end
            end else if (r[2:0] == 3'd0) begin
                // stall burst of 1 to 4 cycles with redirects low
                repeat (int'(r[12:11]) + 1) hold_fetch();
            end else begin
                case (r[7:4])
                    4'd0: drive_cycle(1'b1, 1'b1, rand_target(), 1'b0, 1'b0);
                    4'd1: drive_cycle(1'b1, 1'b1, rand_target(), 1'b1, 1'b0);
                    4'd2: drive_cycle(1'b1, 1'b1, rand_target(), 1'b0, 1'b1);
                    4'd3: drive_cycle(1'b1, 1'b0, 64'h0, 1'b1, 1'b0);
                    4'd4: drive_cycle(1'b1, 1'b0, 64'h0, 1'b0, 1'b1);
                    default: drive_cycle(1'b1, 1'b0, 64'h0, 1'b0, 1'b0);
                endcase
            end
        end
    endtask

    initial begin
        seed     = 32'h3953eabf;
        timeouts = 0;
        rst_n    = 1'b0;
        stall_n  = 1'b0;
        redirect = '0;
        apb_req  = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        // all four halves with random data and read back
        write_csr64(fetch_pkg::MTVEC_LO, {$random(seed), $random(seed)});
        write_csr64(fetch_pkg::MEPC_LO, {$random(seed), $random(seed)});
        read_csrs();
        // window read, unmapped read and unmapped writes leave the registers alone
        apb_xfer(1'b0, `APB_IMEM_BASE + 12'h010, 32'h0);
        apb_xfer(1'b0, 12'h040, 32'h0);
        apb_xfer(1'b1, 12'h040, $random(seed));
        apb_xfer(1'b1, 12'h00E, $random(seed));
        read_csrs();

        load_program();
        write_csr64(fetch_pkg::MTVEC_LO, `RESET_PC + 64'h100);
        write_csr64(fetch_pkg::MEPC_LO, `RESET_PC + 64'h3F4);
        wait_first_fetch();
        run_sequential(40);

        // jump beats a trap flag in the same cycle
        drive_cycle(1'b1, 1'b1, rand_target(), 1'b1, 1'b0);
        drive_cycle(1'b1, 1'b1, rand_target(), 1'b0, 1'b1);
        run_sequential(3);
        drive_cycle(1'b1, 1'b0, 64'h0, 1'b1, 1'b0);
        run_sequential(5);
        drive_cycle(1'b1, 1'b0, 64'h0, 1'b0, 1'b1);
        run_sequential(5);

        // new mtvec near the top so sequential fetch wraps to slot 0
        hold_fetch();
        write_csr64(fetch_pkg::MTVEC_LO, `RESET_PC + 64'h7F8);
        drive_cycle(1'b1, 1'b0, 64'h0, 1'b1, 1'b0);
        run_sequential(4);

        run_random(3000);
        hold_fetch();
        read_csrs();
        repeat (3) @(posedge clk);
        // counters settle after the checker's last edge
        @(negedge clk);

        $display("checks %0d, errors %0d, timeouts %0d", chk_cnt, err_cnt, timeouts);
        if (err_cnt == 0 && timeouts == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+verilog
verilog/fetch_pkg.sv
verilog/if_stage.sv
verilog/imem_sram.sv
verilog/fetch_csr_apb.sv
verilog/fetch_top.sv
bench/fetch_checker.sv
bench/tb_fetch.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/10ps \
    --top-module tb_fetch -f list.f -o tb_fetch

# the simulation result is taken from its printed output
out=$(./obj_dir/tb_fetch 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "Test OK"; then
    exit 0
fi
exit 1
